//--- hdl/dderby_pkg.sv
//==============================
// shared constants for the control and boot subsystem
// keyboard scan codes, joystick bit map, widths and
// the reset countdown values
//==============================

package dderby_pkg;

	//==============================
	// widths
	//==============================

	localparam int joy_w       = 8;  // one joystick byte
	localparam int angle_w     = 6;  // wheel angle, wraps mod 64
	localparam int num_players = 4;

	//==============================
	// joystick byte layout
	//==============================

	localparam int joy_right_bit = 0;
	localparam int joy_left_bit  = 1;
	localparam int joy_fire1_bit = 4;
	localparam int joy_fire2_bit = 5;

	//==============================
	// keyboard scan codes (set 2)
	//==============================

	localparam logic [7:0] key_left   = 8'h6B; // cursor left
	localparam logic [7:0] key_right  = 8'h74; // cursor right
	localparam logic [7:0] key_coin   = 8'h76; // esc
	localparam logic [7:0] key_start1 = 8'h05; // f1
	localparam logic [7:0] key_start2 = 8'h06; // f2
	localparam logic [7:0] key_start3 = 8'h04; // f3
	localparam logic [7:0] key_start4 = 8'h0C; // f4
	localparam logic [7:0] key_fire1  = 8'h29; // space
	localparam logic [7:0] key_fire2  = 8'h11; // alt

	//==============================
	// game reset countdown
	//==============================

	// second reset pulse comes this many cycles after the first one ends
	localparam int rst_count_w = 16;
	localparam logic [rst_count_w-1:0] rst_count_max = {rst_count_w{1'b1}};

endpackage

//--- hdl/key_decoder.sv
//==============================
// keyboard decoder
// turns scan-code strobes into held button levels
// for steering, fire, coin and the four start keys
//==============================

`timescale 1ns/1ns

module key_decoder (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       key_strobe,   // one cycle per key event
	input  logic [7:0] key_code,
	input  logic       key_pressed,  // 1 = make, 0 = break
	output logic       kb_left,
	output logic       kb_right,
	output logic       kb_fire1,
	output logic       kb_fire2,
	output logic       coin,
	output logic [3:0] start
);

	// one level register per mapped key
	logic btn_left;
	logic btn_right;
	logic btn_fire1;
	logic btn_fire2;
	logic btn_coin;
	logic [3:0] btn_start;  // bit 0 is player one

	//==============================
	// scan-code latch
	//==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			btn_left  <= 1'b0;
			btn_right <= 1'b0;
			btn_fire1 <= 1'b0;
			btn_fire2 <= 1'b0;
			btn_coin  <= 1'b0;
			btn_start <= '0;
		end else if (key_strobe) begin
			case (key_code)
				dderby_pkg::key_left:   btn_left     <= key_pressed;
				dderby_pkg::key_right:  btn_right    <= key_pressed;
				dderby_pkg::key_fire1:  btn_fire1    <= key_pressed;
				dderby_pkg::key_fire2:  btn_fire2    <= key_pressed;
				dderby_pkg::key_coin:   btn_coin     <= key_pressed;
				dderby_pkg::key_start1: btn_start[0] <= key_pressed;
				dderby_pkg::key_start2: btn_start[1] <= key_pressed;
				dderby_pkg::key_start3: btn_start[2] <= key_pressed;
				dderby_pkg::key_start4: btn_start[3] <= key_pressed;
				default: ;  // unmapped keys are ignored
			endcase
		end
	end

	//==============================
	// outputs
	//==============================

	assign kb_left  = btn_left;
	assign kb_right = btn_right;
	assign kb_fire1 = btn_fire1;
	assign kb_fire2 = btn_fire2;
	assign coin     = btn_coin;
	assign start    = btn_start;

endmodule

//--- hdl/control_merge.sv
//==============================
// control merger
// optional swap of the first two joysticks, keyboard
// ORed into player one, registered per-player controls
//==============================

`timescale 1ns/1ns

module control_merge (
	input  logic                                clk_sys,
	input  logic                                rst_n,
	input  logic                                swap_joy,
	input  logic [dderby_pkg::joy_w-1:0]        joy_0,
	input  logic [dderby_pkg::joy_w-1:0]        joy_1,
	input  logic [dderby_pkg::joy_w-1:0]        joy_2,
	input  logic [dderby_pkg::joy_w-1:0]        joy_3,
	input  logic                                kb_left,
	input  logic                                kb_right,
	input  logic                                kb_fire1,
	input  logic                                kb_fire2,
	output logic [dderby_pkg::num_players-1:0]  left,
	output logic [dderby_pkg::num_players-1:0]  right,
	output logic [dderby_pkg::num_players-1:0]  fire1,
	output logic [dderby_pkg::num_players-1:0]  fire2
);

	logic [dderby_pkg::joy_w-1:0] joy_p [dderby_pkg::num_players];  // per-player byte

	logic [dderby_pkg::num_players-1:0] left_c;
	logic [dderby_pkg::num_players-1:0] right_c;
	logic [dderby_pkg::num_players-1:0] fire1_c;
	logic [dderby_pkg::num_players-1:0] fire2_c;

	// players 1 and 2 trade sticks when swapped
	assign joy_p[0] = swap_joy ? joy_1 : joy_0;
	assign joy_p[1] = swap_joy ? joy_0 : joy_1;
	assign joy_p[2] = joy_2;
	assign joy_p[3] = joy_3;

	//==============================
	// bit extraction and keyboard OR
	//==============================

	always_comb begin
		for (int p = 0; p < dderby_pkg::num_players; p++) begin
			left_c[p]  = joy_p[p][dderby_pkg::joy_left_bit];
			right_c[p] = joy_p[p][dderby_pkg::joy_right_bit];
			fire1_c[p] = joy_p[p][dderby_pkg::joy_fire1_bit];
			fire2_c[p] = joy_p[p][dderby_pkg::joy_fire2_bit];
		end
		// keyboard only drives player one
		left_c[0]  = left_c[0]  | kb_left;
		right_c[0] = right_c[0] | kb_right;
		fire1_c[0] = fire1_c[0] | kb_fire1;
		fire2_c[0] = fire2_c[0] | kb_fire2;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			left  <= '0;
			right <= '0;
			fire1 <= '0;
			fire2 <= '0;
		end else begin
			left  <= left_c;
			right <= right_c;
			fire1 <= fire1_c;
			fire2 <= fire2_c;
		end
	end

endmodule

//--- hdl/spinner.sv
//==============================
// steering spinner
// wheel angle stepped once per vsync rising edge
// by the held left/right direction
//==============================

`timescale 1ns/1ns

module spinner (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            left,
	input  logic                            right,
	input  logic                            vsync,
	output logic [dderby_pkg::angle_w-1:0]  angle
);

	logic vsync_d;     // previous vsync level
	logic vsync_rise;

	logic [dderby_pkg::angle_w-1:0] angle_q;
	logic [dderby_pkg::angle_w-1:0] angle_next;

	//==============================
	// frame tick
	//==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vsync_d <= 1'b0;
		end else begin
			vsync_d <= vsync;
		end
	end

	assign vsync_rise = vsync & ~vsync_d;

	//==============================
	// angle counter
	//==============================

	// both or neither held means no turn
	always_comb begin
		angle_next = angle_q;
		if (right && !left) begin
			angle_next = angle_q + 1'b1;  // wraps 63 -> 0
		end else if (left && !right) begin
			angle_next = angle_q - 1'b1;  // wraps 0 -> 63
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			angle_q <= '0;
		end else if (vsync_rise) begin
			angle_q <= angle_next;
		end
	end

	assign angle = angle_q;

endmodule

//--- hdl/boot_sequencer.sv
//==============================
// boot sequencer
// ROM download tracking, memory request toggle and
// game reset with the delayed second pulse
//==============================

`timescale 1ns/1ns

module boot_sequencer (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic downloading,  // ROM download in progress
	input  logic dl_wr,        // byte strobe level
	input  logic reset_req,    // menu reset or button
	output logic rom_req,
	output logic rom_loaded,
	output logic game_reset
);

	logic dl_wr_d;
	logic downloading_d;
	logic dl_wr_rise;
	logic dl_done;   // falling edge of downloading
	logic hold_rst;  // reset requested or nothing loaded yet

	logic req_q;
	logic loaded_q;
	logic game_reset_q;
	logic [dderby_pkg::rst_count_w-1:0] rst_count;

	//==============================
	// edge detection
	//==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_wr_d       <= 1'b0;
			downloading_d <= 1'b0;
		end else begin
			dl_wr_d       <= dl_wr;
			downloading_d <= downloading;
		end
	end

	assign dl_wr_rise = dl_wr & ~dl_wr_d;
	assign dl_done    = downloading_d & ~downloading;

	//==============================
	// download tracking
	//==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			req_q    <= 1'b0;
			loaded_q <= 1'b0;
		end else begin
			if (downloading && dl_wr_rise)
				req_q <= ~req_q;  // one toggle per byte
			if (dl_done)
				loaded_q <= 1'b1;  // sticky until rst_n
		end
	end

	//==============================
	// game reset
	//==============================

	assign hold_rst = reset_req | ~loaded_q;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rst_count    <= dderby_pkg::rst_count_max;
			game_reset_q <= 1'b1;
		end else begin
			if (hold_rst)
				rst_count <= dderby_pkg::rst_count_max;
			else if (rst_count != '0)
				rst_count <= rst_count - 1'b1;  // stops at zero
			// second pulse when the countdown passes one
			game_reset_q <= hold_rst | (rst_count == 1);
		end
	end

	assign rom_req    = req_q;
	assign rom_loaded = loaded_q;
	assign game_reset = game_reset_q;

endmodule

//--- hdl/dderby_inputs.sv
//==============================
// control and boot top level
// key decoder, control merger, four spinners
// and the boot sequencer
//==============================

`timescale 1ns/1ns

module dderby_inputs (
	input  logic                                clk_sys,
	input  logic                                rst_n,
	input  logic                                key_strobe,
	input  logic [7:0]                          key_code,
	input  logic                                key_pressed,
	input  logic [dderby_pkg::joy_w-1:0]        joy_0,
	input  logic [dderby_pkg::joy_w-1:0]        joy_1,
	input  logic [dderby_pkg::joy_w-1:0]        joy_2,
	input  logic [dderby_pkg::joy_w-1:0]        joy_3,
	input  logic                                swap_joy,
	input  logic                                vsync,
	input  logic                                downloading,
	input  logic                                dl_wr,
	input  logic                                reset_req,
	output logic                                coin,
	output logic [3:0]                          start,
	output logic [dderby_pkg::num_players-1:0]  fire1,
	output logic [dderby_pkg::num_players-1:0]  fire2,
	output logic [dderby_pkg::angle_w-1:0]      wheel1,
	output logic [dderby_pkg::angle_w-1:0]      wheel2,
	output logic [dderby_pkg::angle_w-1:0]      wheel3,
	output logic [dderby_pkg::angle_w-1:0]      wheel4,
	output logic                                rom_req,
	output logic                                rom_loaded,
	output logic                                game_reset
);

	logic kb_left;
	logic kb_right;
	logic kb_fire1;
	logic kb_fire2;

	// merged steering, one bit per player
	logic [dderby_pkg::num_players-1:0] left;
	logic [dderby_pkg::num_players-1:0] right;

	key_decoder u_keys (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.kb_left     (kb_left),
		.kb_right    (kb_right),
		.kb_fire1    (kb_fire1),
		.kb_fire2    (kb_fire2),
		.coin        (coin),
		.start       (start)
	);

	control_merge u_merge (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.swap_joy (swap_joy),
		.joy_0    (joy_0),
		.joy_1    (joy_1),
		.joy_2    (joy_2),
		.joy_3    (joy_3),
		.kb_left  (kb_left),
		.kb_right (kb_right),
		.kb_fire1 (kb_fire1),
		.kb_fire2 (kb_fire2),
		.left     (left),
		.right    (right),
		.fire1    (fire1),
		.fire2    (fire2)
	);

	//==============================
	// spinners, shared vsync
	//==============================

	spinner u_spin1 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.left    (left[0]),
		.right   (right[0]),
		.vsync   (vsync),
		.angle   (wheel1)
	);

	spinner u_spin2 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.left    (left[1]),
		.right   (right[1]),
		.vsync   (vsync),
		.angle   (wheel2)
	);

	spinner u_spin3 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.left    (left[2]),
		.right   (right[2]),
		.vsync   (vsync),
		.angle   (wheel3)
	);

	spinner u_spin4 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.left    (left[3]),
		.right   (right[3]),
		.vsync   (vsync),
		.angle   (wheel4)
	);

	boot_sequencer u_boot (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.downloading (downloading),
		.dl_wr       (dl_wr),
		.reset_req   (reset_req),
		.rom_req     (rom_req),
		.rom_loaded  (rom_loaded),
		.game_reset  (game_reset)
	);

endmodule

//--- bench/input_checker.sv
//==============================
// output checker
// compares DUT outputs with the reference model
// on each falling clock edge and counts errors
//==============================

`timescale 1ns/1ns

module input_checker (
	input  logic                               clk_sys,
	input  logic                               rst_n,
	input  logic                               coin,
	input  logic [3:0]                         start,
	input  logic [dderby_pkg::num_players-1:0] fire1,
	input  logic [dderby_pkg::num_players-1:0] fire2,
	input  logic [dderby_pkg::angle_w-1:0]     wheel1,
	input  logic [dderby_pkg::angle_w-1:0]     wheel2,
	input  logic [dderby_pkg::angle_w-1:0]     wheel3,
	input  logic [dderby_pkg::angle_w-1:0]     wheel4,
	input  logic                               rom_req,
	input  logic                               rom_loaded,
	input  logic                               game_reset,
	input  logic [8:0]                         exp_kb,   // {start, coin, fire2, fire1, right, left}
	input  logic [15:0]                        exp_ctl,  // {fire2, fire1, right, left}
	input  logic [dderby_pkg::num_players-1:0][dderby_pkg::angle_w-1:0] exp_wheel,
	input  logic                               exp_req,
	input  logic                               exp_loaded,
	input  logic                               exp_reset,
	output int                                 err_count,
	output int                                 chk_count
);

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
		chk_count = chk_count + 1;
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("FAIL %s: got %h, expected %h at %0t ns", name, got, exp, $time);
		end
	endtask

	initial begin
		err_count = 0;
		chk_count = 0;
	end

	//==============================
	// compare on the falling edge
	//==============================

	always @(negedge clk_sys) begin
		if (rst_n) begin
			compare("coin", coin, exp_kb[4]);
			compare("start", start, exp_kb[8:5]);
			compare("fire1", fire1, exp_ctl[11:8]);
			compare("fire2", fire2, exp_ctl[15:12]);
			compare("wheel1", wheel1, exp_wheel[0]);
			compare("wheel2", wheel2, exp_wheel[1]);
			compare("wheel3", wheel3, exp_wheel[2]);
			compare("wheel4", wheel4, exp_wheel[3]);
			compare("rom_req", rom_req, exp_req);
			compare("rom_loaded", rom_loaded, exp_loaded);
			compare("game_reset", game_reset, exp_reset);  // long hold and second pulse
		end
	end

endmodule

//--- bench/tb_dderby_inputs.sv
//==============================
// testbench for the control and boot top level
// clock, reset, random stimulus, reference model,
// watchdog and closing report
//==============================

`timescale 1ns/1ns

module tb_dderby_inputs;

	localparam int mix_cycles = 400;
	localparam int dl_cycles  = 80;
	localparam int rst_gap    = int'(dderby_pkg::rst_count_max) + 1;
	localparam int run_cycles = mix_cycles + dl_cycles + 2 * rst_gap + 300;

	// known scan codes, index matches the bit order of exp_kb
	localparam logic [8:0][7:0] codes = {
		dderby_pkg::key_start4, dderby_pkg::key_start3, dderby_pkg::key_start2,
		dderby_pkg::key_start1, dderby_pkg::key_coin, dderby_pkg::key_fire2,
		dderby_pkg::key_fire1, dderby_pkg::key_right, dderby_pkg::key_left
	};

	logic                               clk_sys;
	logic                               rst_n;
	logic                               key_strobe;
	logic [7:0]                         key_code;
	logic                               key_pressed;
	logic [dderby_pkg::joy_w-1:0]       joy_0;
	logic [dderby_pkg::joy_w-1:0]       joy_1;
	logic [dderby_pkg::joy_w-1:0]       joy_2;
	logic [dderby_pkg::joy_w-1:0]       joy_3;
	logic                               swap_joy;
	logic                               vsync;
	logic                               downloading;
	logic                               dl_wr;
	logic                               reset_req;
	logic                               coin;
	logic [3:0]                         start;
	logic [dderby_pkg::num_players-1:0] fire1;
	logic [dderby_pkg::num_players-1:0] fire2;
	logic [dderby_pkg::angle_w-1:0]     wheel1;
	logic [dderby_pkg::angle_w-1:0]     wheel2;
	logic [dderby_pkg::angle_w-1:0]     wheel3;
	logic [dderby_pkg::angle_w-1:0]     wheel4;
	logic                               rom_req;
	logic                               rom_loaded;
	logic                               game_reset;

	//==============================
	// reference model state
	//==============================

	logic [8:0]  exp_kb;   // {start, coin, fire2, fire1, right, left}
	logic [15:0] exp_ctl;  // {fire2, fire1, right, left}, one nibble each
	logic [dderby_pkg::num_players-1:0][dderby_pkg::angle_w-1:0] exp_wheel;
	logic        vsync_m;
	logic        dl_wr_m;
	logic        dl_m;
	logic        exp_req;
	logic        exp_loaded;
	logic        exp_reset;
	logic [dderby_pkg::rst_count_w-1:0] exp_count;

	int          seed;
	logic [31:0] rnd;
	int          i;
	int          err_count;
	int          chk_count;

	dderby_inputs u_dut (.*);

	input_checker u_chk (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	//==============================
	// reference functions
	//==============================

	function automatic logic [8:0] key_map(logic [8:0] lv, logic [7:0] code, logic pressed);
		logic [8:0] n;
		int k;
		n = lv;
		for (k = 0; k < 9; k++)
			if (code == codes[k])
				n[k] = pressed;  // unknown codes match nothing
		return n;
	endfunction

	function automatic logic [15:0] merge_ref(logic [31:0] joys, logic swap, logic [3:0] kb);
		logic [15:0] m;
		logic [7:0]  j;
		int          src;
		int          p;
		m = '0;
		for (p = 0; p < 4; p++) begin
			src = (swap && p < 2) ? 1 - p : p;  // players 1 and 2 trade sticks
			j = joys[8 * src +: 8];
			m[p]      = j[dderby_pkg::joy_left_bit];
			m[4 + p]  = j[dderby_pkg::joy_right_bit];
			m[8 + p]  = j[dderby_pkg::joy_fire1_bit];
			m[12 + p] = j[dderby_pkg::joy_fire2_bit];
		end
		// keyboard joins player 1 only
		return m | {kb[3], 3'b000, kb[2], 3'b000, kb[1], 3'b000, kb[0]};
	endfunction

	function automatic logic [dderby_pkg::angle_w-1:0] next_angle(
		logic [dderby_pkg::angle_w-1:0] a, logic l, logic r);
		if (r && !l)
			return a + 1'b1;  // mod 64 by width
		else if (l && !r)
			return a - 1'b1;
		return a;
	endfunction

	// next {game_reset, countdown}
	function automatic logic [dderby_pkg::rst_count_w:0] reset_step(
		logic [dderby_pkg::rst_count_w-1:0] cnt, logic hold);
		logic [dderby_pkg::rst_count_w-1:0] nxt;
		if (hold)
			nxt = dderby_pkg::rst_count_max;
		else
			nxt = (cnt == 0) ? cnt : cnt - 1'b1;
		return {hold | (cnt == 1), nxt};
	endfunction

	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			exp_kb     <= '0;
			exp_ctl    <= '0;
			exp_wheel  <= '0;
			vsync_m    <= 1'b0;
			dl_wr_m    <= 1'b0;
			dl_m       <= 1'b0;
			exp_req    <= 1'b0;
			exp_loaded <= 1'b0;
			exp_count  <= dderby_pkg::rst_count_max;
			exp_reset  <= 1'b1;
		end else begin
			if (key_strobe)
				exp_kb <= key_map(exp_kb, key_code, key_pressed);
			exp_ctl <= merge_ref({joy_3, joy_2, joy_1, joy_0}, swap_joy, exp_kb[3:0]);
			if (vsync && !vsync_m) begin
				exp_wheel[0] <= next_angle(exp_wheel[0], exp_ctl[0], exp_ctl[4]);
				exp_wheel[1] <= next_angle(exp_wheel[1], exp_ctl[1], exp_ctl[5]);
				exp_wheel[2] <= next_angle(exp_wheel[2], exp_ctl[2], exp_ctl[6]);
				exp_wheel[3] <= next_angle(exp_wheel[3], exp_ctl[3], exp_ctl[7]);
			end
			vsync_m <= vsync;
			dl_wr_m <= dl_wr;
			dl_m    <= downloading;
			if (downloading && dl_wr && !dl_wr_m)
				exp_req <= ~exp_req;
			if (dl_m && !downloading)
				exp_loaded <= 1'b1;
			{exp_reset, exp_count} <= reset_step(exp_count, reset_req | ~exp_loaded);
		end
	end

	// held reset, low phase, second pulse, back low
	task automatic wait_second_pulse;
		while (!rom_loaded || game_reset)
			@(negedge clk_sys);
		while (!game_reset)
			@(negedge clk_sys);
		while (game_reset)
			@(negedge clk_sys);
	endtask

	//==============================
	// stimulus
	//==============================

	initial begin
		seed        = 32'h347f7608;
		rst_n       <= 1'b0;
		key_strobe  <= 1'b0;
		key_code    <= 8'h00;
		key_pressed <= 1'b0;
		joy_0       <= '0;
		joy_1       <= '0;
		joy_2       <= '0;
		joy_3       <= '0;
		swap_joy    <= 1'b0;
		vsync       <= 1'b0;
		downloading <= 1'b0;
		dl_wr       <= 1'b0;
		reset_req   <= 1'b0;
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;

		// keys, joysticks and vsync together
		for (i = 0; i < mix_cycles; i++) begin
			@(posedge clk_sys);
			rnd = $random(seed);
			key_strobe  <= (rnd[1:0] == 2'b00);
			key_code    <= (rnd[5:2] < 9) ? codes[rnd[5:2]] : rnd[31:24];
			key_pressed <= rnd[6];
			dl_wr       <= rnd[7];  // no download yet
			vsync       <= (i % 16) < 3;
			if (i % 8 == 0) begin
				swap_joy <= rnd[8];
				rnd = $random(seed);
				joy_0 <= rnd[7:0];
				joy_1 <= rnd[15:8];
				joy_2 <= rnd[23:16];
				joy_3 <= rnd[31:24];
			end
		end

		// ROM download
		@(posedge clk_sys);
		key_strobe  <= 1'b0;
		vsync       <= 1'b0;
		downloading <= 1'b1;
		for (i = 0; i < dl_cycles; i++) begin
			@(posedge clk_sys);
			rnd = $random(seed);
			dl_wr <= rnd[0];
		end
		@(posedge clk_sys);
		downloading <= 1'b0;
		for (i = 0; i < 10; i++) begin  // stray strobes after the download
			@(posedge clk_sys);
			rnd = $random(seed);
			dl_wr <= rnd[0];
		end
		wait_second_pulse();

		// menu reset restarts the countdown
		@(posedge clk_sys);
		reset_req <= 1'b1;
		repeat (4) @(posedge clk_sys);
		reset_req <= 1'b0;
		wait_second_pulse();

		repeat (20) @(posedge clk_sys);
		$display("checks %0d, errors %0d", chk_count, err_count);
		if (err_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		#(run_cycles * 10);
		$display("watchdog expired, run did not finish within %0d cycles", run_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- list.f
hdl/dderby_pkg.sv
hdl/key_decoder.sv
hdl/control_merge.sv
hdl/spinner.sv
hdl/boot_sequencer.sv
hdl/dderby_inputs.sv
bench/input_checker.sv
bench/tb_dderby_inputs.sv

//--- Bender.yml
package:
  name: dderby_inputs

sources:
  - hdl/dderby_pkg.sv
  - hdl/key_decoder.sv
  - hdl/control_merge.sv
  - hdl/spinner.sv
  - hdl/boot_sequencer.sv
  - hdl/dderby_inputs.sv
  - target: test
    files:
      - bench/input_checker.sv
      - bench/tb_dderby_inputs.sv
